//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f vlog.f --top-module aa_bridge_tb -o aa_bridge_sim \
  || exit 1
./obj_dir/aa_bridge_sim | tee /dev/stderr | grep -q "all tests passed" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- verification/aa_bridge_tb.sv
// bridge testbench
// table of local and remote operations, reference model of the block,
// stream sink and lite master slave with random stalls, compare tasks
`timescale 1ns/1ps

module aa_bridge_tb
  import aa_bus_pkg::*, aa_map_pkg::*;
;

  localparam int wait_max = 200;
  // local block addresses and remote mailbox base
  localparam logic [31:0] l_en = 32'h2100;
  localparam logic [31:0] l_st = 32'h2104;
  localparam logic [31:0] l_mb = 32'h2000;
  localparam logic [31:0] r_mb = 32'h0002000;

  typedef enum logic [1:0] {op_lwr, op_lrd, op_rwr, op_lwr_off} op_e;

  typedef struct packed {
    op_e         kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic        exp_irq;
  } row_t;

  logic axis_clk, axis_rst_n;
  logic s_awvalid, s_wvalid, s_arvalid, s_rready, s_awready, s_wready, s_arready, s_rvalid;
  logic [lite_addr_w-1:0] s_awaddr, s_araddr;
  logic [data_w-1:0] s_wdata, s_rdata;
  logic [strb_w-1:0] s_wstrb;
  logic m_awvalid, m_wvalid, m_awready, m_wready;
  lite_wr_t m_aw_w;
  logic ss_tvalid, ss_tready, sm_tvalid, sm_tready, cc_aa_enable, mb_irq;
  axis_beat_t ss_beat, sm_beat;

  row_t rows[$];
  // reference model of the register block
  logic [data_w-1:0] model_mbox [mbox_words];
  logic model_en;
  logic model_st;

  aa_clock_gen u_clk (.axis_clk(axis_clk), .axis_rst_n(axis_rst_n));

  aa_bridge_top dut (.*);

  // --------------------------------------------------------------------------
  // failure reporting and compare tasks
  // --------------------------------------------------------------------------
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                            input string what);
    if (got !== exp) stop_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                        $time, what, got, exp));
  endtask

  task automatic check_beat(input axis_beat_t got, input axis_beat_t exp, input string what);
    if (got !== exp) stop_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                        $time, what, got, exp));
  endtask

  task automatic check_lite_wr(input lite_wr_t got, input lite_wr_t exp, input string what);
    if (got !== exp) stop_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                        $time, what, got, exp));
  endtask

  task automatic check_irq(input logic got, input logic exp, input string what);
    if (got !== exp) stop_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                        $time, what, got, exp));
  endtask

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic void update_mbox(input logic [2:0] idx, input logic [data_w-1:0] data,
                                      input logic [strb_w-1:0] strb);
    for (int b = 0; b < strb_w; b++) begin
      if (strb[b]) model_mbox[idx][8*b +: 8] = data[8*b +: 8];
    end
  endfunction

  function automatic logic [data_w-1:0] model_read(input logic [lite_addr_w-1:0] addr);
    if (ls_hit_regs(addr)) return {31'b0, addr[status_off_bit] ? model_st : model_en};
    if (ls_hit_mbox(addr)) return model_mbox[addr[4:2]];
    // outside the block reads give zero
    return '0;
  endfunction

  // forwarded beat with the header {strobe, address} first and raw data second
  function automatic axis_beat_t fwd_beat(input logic hdr, input logic [lite_addr_w-1:0] addr,
                                          input logic [data_w-1:0] data,
                                          input logic [strb_w-1:0] strb);
    axis_beat_t b;
    b = '0;
    if (hdr) begin
      b.tdata.hdr.strb = strb;
      b.tdata.hdr.addr = {13'b0, addr};
    end else begin
      b.tdata.raw = data;
    end
    b.tstrb = strb;
    b.tlast = 1'b1;
    b.tuser = lite_write;
    return b;
  endfunction

  function automatic row_t make_row(input op_e kind, input logic [31:0] addr,
                                    input logic [31:0] data, input logic [3:0] strb,
                                    input logic exp_irq);
    return {kind, addr, data, strb, exp_irq};
  endfunction

  // --------------------------------------------------------------------------
  // bus models
  // --------------------------------------------------------------------------
  // local write held off with enable low for off_cycles when that is nonzero
  task automatic local_write(input logic [lite_addr_w-1:0] addr, input logic [data_w-1:0] data,
                             input logic [strb_w-1:0] strb, input int off_cycles);
    axis_beat_t exp_beats [2];
    int n_exp;
    int nbeat;
    int cyc;
    logic aw_done;
    n_exp = 0;
    nbeat = 0;
    cyc = 0;
    aw_done = 1'b0;
    if (ls_hit_regs(addr)) begin
      if (strb[0] && !addr[status_off_bit]) model_en = data[0];
      if (strb[0] && addr[status_off_bit] && data[0]) model_st = 1'b0;
    end else begin
      // mailbox words update locally and also go to the peer
      if (ls_hit_mbox(addr)) update_mbox(addr[4:2], data, strb);
      exp_beats[0] = fwd_beat(1'b1, addr, data, strb);
      exp_beats[1] = fwd_beat(1'b0, addr, data, strb);
      n_exp = 2;
    end
    s_awaddr = addr;
    s_wdata = data;
    s_wstrb = strb;
    s_awvalid = 1'b1;
    s_wvalid = 1'b1;
    if (off_cycles > 0) begin
      cc_aa_enable = 1'b0;
      repeat (off_cycles) begin
        @(negedge axis_clk);
        if (s_awready || sm_tvalid) stop_run("write was accepted while the bridge was disabled");
      end
      cc_aa_enable = 1'b1;
    end
    while (!(aw_done && nbeat == n_exp)) begin
      @(negedge axis_clk);
      cyc++;
      if (cyc > wait_max) stop_run("timeout on a local write");
      if (aw_done) begin
        s_awvalid = 1'b0;
        s_wvalid = 1'b0;
      end
      if (s_wready !== s_awready) stop_run("s_wready and s_awready differ");
      // stream sink with random stalls
      sm_tready = 1'b0;
      if (sm_tvalid) begin
        if (nbeat >= n_exp) stop_run("unexpected stream beat on a local write");
        check_beat(sm_beat, exp_beats[nbeat], "forwarded beat");
        if ($urandom % 3 != 0) begin
          sm_tready = 1'b1;
          nbeat++;
        end
      end
      if (s_awready && !aw_done) begin
        aw_done = 1'b1;
        if (n_exp == 2 && !ls_hit_mbox(addr)) begin
          if (nbeat != 2) stop_run("awready came before the forwarded data beat");
        end else if (cyc != 2) begin
          stop_run($sformatf("MISMATCH at %0t: awready after %0d cycles, expected 2",
                             $time, cyc));
        end
      end
    end
    @(negedge axis_clk);
    s_awvalid = 1'b0;
    s_wvalid = 1'b0;
    sm_tready = 1'b0;
  endtask

  task automatic local_read(input logic [lite_addr_w-1:0] addr);
    int cyc;
    int n_ar;
    cyc = 0;
    n_ar = 0;
    s_araddr = addr;
    s_arvalid = 1'b1;
    s_rready = 1'b1;
    while (!s_rvalid) begin
      @(negedge axis_clk);
      cyc++;
      if (cyc > wait_max) stop_run("timeout waiting for read data");
      if (s_arready) n_ar++;
    end
    if (n_ar != 1) stop_run("s_arready was not seen exactly once before read data");
    if (cyc != 2) stop_run($sformatf("MISMATCH at %0t: rvalid after %0d cycles, expected 2",
                                     $time, cyc));
    check_word(s_rdata, model_read(addr), $sformatf("read of %h", addr));
    s_arvalid = 1'b0;
    @(negedge axis_clk);
    s_rready = 1'b0;
  endtask

  // drives one stream beat and returns at the falling edge after the transfer
  task automatic send_beat(input axis_beat_t beat);
    int cyc;
    cyc = 0;
    ss_beat = beat;
    ss_tvalid = 1'b1;
    while (!ss_tready) begin
      @(negedge axis_clk);
      cyc++;
      if (cyc > wait_max) stop_run("timeout waiting for ss_tready");
    end
    @(negedge axis_clk);
  endtask

  task automatic remote_write(input logic [27:0] addr, input logic [data_w-1:0] data,
                              input logic [strb_w-1:0] strb);
    axis_beat_t beat;
    lite_wr_t exp_wr;
    int cyc;
    int delay;
    if (rs_hit_mbox(addr)) begin
      update_mbox(addr[4:2], data, strb);
      if (|strb) model_st = 1'b1;
    end
    if (rs_hit_regs(addr) && !addr[status_off_bit] && strb[0]) model_en = data[0];
    exp_wr.addr = {lm_addr_top, addr};
    exp_wr.data = data;
    exp_wr.strb = strb;
    beat = '0;
    beat.tdata.hdr.strb = strb;
    beat.tdata.hdr.addr = addr;
    beat.tlast = 1'b1;
    beat.tuser = lite_write;
    send_beat(beat);
    beat.tdata.raw = data;
    send_beat(beat);
    ss_tvalid = 1'b0;
    if (!(rs_hit_regs(addr) || rs_hit_mbox(addr))) begin
      // wready may come a cycle before awready
      delay = int'($urandom % 5);
      cyc = 0;
      while (!m_awready) begin
        @(negedge axis_clk);
        cyc++;
        if (cyc > wait_max) stop_run("timeout waiting for the master write");
        if (m_wvalid !== m_awvalid) stop_run("m_wvalid and m_awvalid differ");
        if (m_awvalid) begin
          check_lite_wr(m_aw_w, exp_wr, "master write");
          if (delay <= 1) m_wready = 1'b1;
          if (delay == 0) m_awready = 1'b1;
          delay--;
        end
      end
      @(negedge axis_clk);
      m_awready = 1'b0;
      m_wready = 1'b0;
    end
    cyc = 0;
    while (dut.rx_busy) begin
      @(negedge axis_clk);
      cyc++;
      if (cyc > wait_max) stop_run("stream receiver did not return to idle");
    end
  endtask

  // --------------------------------------------------------------------------
  // table and main sequence
  // --------------------------------------------------------------------------
  initial begin
    row_t r;
    int cyc;
    void'($urandom(32'h1971));
    {s_awvalid, s_wvalid, s_arvalid, s_rready} = '0;
    {s_awaddr, s_araddr, s_wdata, s_wstrb} = '0;
    {m_awready, m_wready, ss_tvalid, sm_tready} = '0;
    ss_beat = '0;
    cc_aa_enable = 1'b1;
    model_en = 1'b0;
    model_st = 1'b0;
    // enable bit and mailbox words with partial strobes
    rows.push_back(make_row(op_lrd, l_en, 32'h0, 4'h0, 1'b0));
    rows.push_back(make_row(op_lwr, l_en, 32'h1, 4'h1, 1'b0));
    rows.push_back(make_row(op_lwr, l_en, 32'h0, 4'he, 1'b0));
    rows.push_back(make_row(op_lrd, l_en, 32'h0, 4'h0, 1'b0));
    rows.push_back(make_row(op_lwr, l_mb, 32'h11223344, 4'hf, 1'b0));
    rows.push_back(make_row(op_lwr, l_mb + 20, 32'hdeadbeef, 4'hf, 1'b0));
    rows.push_back(make_row(op_lwr, l_mb, 32'haabbccdd, 4'h5, 1'b0));
    rows.push_back(make_row(op_lrd, l_mb, 32'h0, 4'h0, 1'b0));
    // forwarded write followed by an unchanged block word and a zero read outside
    rows.push_back(make_row(op_lwr, 32'h1230, 32'hcafef00d, 4'h3, 1'b0));
    rows.push_back(make_row(op_lrd, l_mb + 20, 32'h0, 4'h0, 1'b0));
    rows.push_back(make_row(op_lrd, 32'h1230, 32'h0, 4'h0, 1'b0));
    // remote writes with master replay and mailbox interrupt
    rows.push_back(make_row(op_rwr, 32'h0abc124, 32'h01020304, 4'h9, 1'b0));
    rows.push_back(make_row(op_rwr, r_mb + 8, 32'h5a5a5a5a, 4'hf, 1'b1));
    rows.push_back(make_row(op_rwr, r_mb + 8, 32'h000000ff, 4'h1, 1'b1));
    rows.push_back(make_row(op_lrd, l_mb + 8, 32'h0, 4'h0, 1'b1));
    rows.push_back(make_row(op_lrd, l_st, 32'h0, 4'h0, 1'b1));
    rows.push_back(make_row(op_lwr, l_st, 32'h1, 4'h1, 1'b0));
    rows.push_back(make_row(op_lrd, l_st, 32'h0, 4'h0, 1'b0));
    // remote enable clear keeps the irq low when status rises
    rows.push_back(make_row(op_rwr, 32'h0002100, 32'h0, 4'h1, 1'b0));
    rows.push_back(make_row(op_rwr, r_mb + 28, 32'h87654321, 4'hf, 1'b0));
    rows.push_back(make_row(op_lwr_off, 32'h6008, 32'h12345678, 4'hf, 1'b0));
    rows.push_back(make_row(op_lwr, l_en, 32'h1, 4'h1, 1'b1));
    rows.push_back(make_row(op_lrd, l_mb + 28, 32'h0, 4'h0, 1'b1));
    rows.push_back(make_row(op_rwr, 32'h5550010, 32'h0badf00d, 4'h6, 1'b1));
    cyc = 0;
    while (!axis_rst_n) begin
      @(negedge axis_clk);
      cyc++;
      if (cyc > 50) stop_run("reset was never released");
    end
    @(negedge axis_clk);
    check_irq(mb_irq, 1'b0, "mb_irq after reset");
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      case (r.kind)
        op_lwr:     local_write(r.addr[lite_addr_w-1:0], r.data, r.strb, 0);
        op_lwr_off: local_write(r.addr[lite_addr_w-1:0], r.data, r.strb, 20);
        op_lrd:     local_read(r.addr[lite_addr_w-1:0]);
        default:    remote_write(r.addr[27:0], r.data, r.strb);
      endcase
      check_irq(mb_irq, model_en && model_st, $sformatf("mb_irq vs model, row %0d", i));
      check_irq(mb_irq, r.exp_irq, $sformatf("mb_irq vs table, row %0d", i));
    end
    $display("all tests passed");
    $finish;
  end

endmodule

//--- verification/aa_clock_gen.sv
// testbench clock and reset
// 100 ns clock, reset held low for the first 8 cycles
`timescale 1ns/1ps

module aa_clock_gen (
  output logic axis_clk,
  output logic axis_rst_n
);

  initial begin
    axis_clk = 1'b0;
    forever #50 axis_clk = ~axis_clk;
  end

  // release on a rising edge after 8 cycles
  initial begin
    axis_rst_n = 1'b0;
    repeat (8) @(posedge axis_clk);
    axis_rst_n <= 1'b1;
  end

endmodule

//--- verilog/aa_bridge_top.sv
// bridge top level
// stream receiver, lite engine and register block wired to the ports
`timescale 1ns/1ps

module aa_bridge_top
  import aa_bus_pkg::*;
(
  input  logic                   axis_clk,
  input  logic                   axis_rst_n,
  // lite slave
  input  logic                   s_awvalid,
  input  logic [lite_addr_w-1:0] s_awaddr,
  output logic                   s_awready,
  input  logic                   s_wvalid,
  input  logic [data_w-1:0]      s_wdata,
  input  logic [strb_w-1:0]      s_wstrb,
  output logic                   s_wready,
  input  logic                   s_arvalid,
  input  logic [lite_addr_w-1:0] s_araddr,
  output logic                   s_arready,
  output logic                   s_rvalid,
  output logic [data_w-1:0]      s_rdata,
  input  logic                   s_rready,
  // lite master write
  output logic                   m_awvalid,
  output logic                   m_wvalid,
  output lite_wr_t               m_aw_w,
  input  logic                   m_awready,
  input  logic                   m_wready,
  // stream in and out
  input  logic                   ss_tvalid,
  input  axis_beat_t             ss_beat,
  output logic                   ss_tready,
  output logic                   sm_tvalid,
  output axis_beat_t             sm_beat,
  input  logic                   sm_tready,
  // misc
  input  logic                   cc_aa_enable,
  output logic                   mb_irq
);

  logic              rx_busy;
  reg_wr_t           rx_reg_wr;
  reg_wr_t           ls_reg_wr;
  logic [3:0]        rd_word_sel;
  logic [data_w-1:0] rd_data;

  aa_stream_rx u_rx (.*);

  aa_lite_engine u_ls (.*);

  aa_mailbox u_mb (.*);

endmodule

//--- verilog/aa_bus_pkg.sv
// bus types shared by the bridge
// stream beat with its header/data union, lite master write request,
// and the register block write request
package aa_bus_pkg;

  // ---------------------------------------------------------------------------
  // widths
  // ---------------------------------------------------------------------------
  localparam int data_w      = 32;
  localparam int strb_w      = 4;
  localparam int lite_addr_w = 15;

  // stream cycle type carried on tuser
  // only lite_write is produced or accepted by this bridge
  typedef enum logic [1:0] {
    axis          = 2'b00,
    lite_write    = 2'b01,
    lite_read_req = 2'b10,
    lite_read_cpl = 2'b11
  } tuser_e;

  // first beat of a forwarded write
  // strobe sits in the top nibble, address below it
  typedef struct packed {
    logic [strb_w-1:0] strb;
    logic [27:0]       addr;
  } stream_hdr_t;

  // one tdata word seen two ways
  // header view on the first beat, raw data on the second
  typedef union packed {
    stream_hdr_t       hdr;
    logic [data_w-1:0] raw;
  } stream_word_u;

  // stream beat payload, valid/ready kept outside
  typedef struct packed {
    stream_word_u      tdata;
    logic [strb_w-1:0] tstrb;
    logic [strb_w-1:0] tkeep;
    logic              tlast;
    tuser_e            tuser;
  } axis_beat_t;

  // lite master write channel payload, aw and w together
  typedef struct packed {
    logic [31:0]       addr;
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
  } lite_wr_t;

  // write into the local register block
  // sel_regs picks the enable/status page, otherwise a mailbox word
  typedef struct packed {
    logic              valid;
    logic              sel_regs;
    logic [2:0]        idx;
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
  } reg_wr_t;

endpackage

//--- verilog/aa_lite_engine.sv
// local lite slave engine
// answers reads and writes of the local block, forwards other writes
// and mailbox writes to the peer as two stream beats
`timescale 1ns/1ps

module aa_lite_engine
  import aa_bus_pkg::*, aa_map_pkg::*;
(
  input  logic                   axis_clk,
  input  logic                   axis_rst_n,
  input  logic                   cc_aa_enable,
  // lite slave
  input  logic                   s_awvalid,
  input  logic                   s_wvalid,
  input  logic                   s_arvalid,
  input  logic                   s_rready,
  input  logic [lite_addr_w-1:0] s_awaddr,
  input  logic [lite_addr_w-1:0] s_araddr,
  input  logic [data_w-1:0]      s_wdata,
  input  logic [strb_w-1:0]      s_wstrb,
  output logic                   s_awready,
  output logic                   s_wready,
  output logic                   s_arready,
  output logic                   s_rvalid,
  output logic [data_w-1:0]      s_rdata,
  // stream out
  output logic                   sm_tvalid,
  output axis_beat_t             sm_beat,
  input  logic                   sm_tready,
  // receiver and register block
  input  logic                   rx_busy,
  output reg_wr_t                ls_reg_wr,
  output logic [3:0]             rd_word_sel,
  input  logic [data_w-1:0]      rd_data
);

  typedef enum logic [3:0] {
    ls_idle, ls_wr_dec, ls_rd_dec, ls_wr_sm1, ls_wr_sm2,
    ls_wr_done, ls_rd_done, ls_mb_ack, ls_mb_sm1, ls_mb_sm2
  } ls_state_e;

  ls_state_e              state;
  logic [lite_addr_w-1:0] r_addr;
  logic [data_w-1:0]      r_data;
  logic [strb_w-1:0]      r_strb;
  logic                   wr_req;
  logic                   accept;
  logic                   hit_regs;
  logic                   hit_mbox;
  logic                   hdr_beat;

  // write wins over read when both are offered
  assign wr_req   = s_awvalid && s_wvalid;
  assign accept   = (state == ls_idle) && cc_aa_enable && !rx_busy && (wr_req || s_arvalid);
  assign hit_regs = ls_hit_regs(r_addr);
  assign hit_mbox = ls_hit_mbox(r_addr);

  // ---------------------------------------------------------------------------
  // control
  // ---------------------------------------------------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state <= ls_idle;
    end else begin
      case (state)
        ls_idle:    if (accept) state <= wr_req ? ls_wr_dec : ls_rd_dec;
        ls_wr_dec: begin
          if (hit_regs)      state <= ls_wr_done;
          else if (hit_mbox) state <= ls_mb_ack;
          else               state <= ls_wr_sm1;
        end
        ls_wr_sm1:  if (sm_tready) state <= ls_wr_sm2;
        ls_wr_sm2:  if (sm_tready) state <= ls_wr_done;
        ls_wr_done: state <= ls_idle;
        ls_rd_dec:  state <= ls_rd_done;
        ls_rd_done: if (s_rready) state <= ls_idle;
        // mailbox writes ack locally before forwarding
        ls_mb_ack:  state <= ls_mb_sm1;
        ls_mb_sm1:  if (sm_tready) state <= ls_mb_sm2;
        ls_mb_sm2:  if (sm_tready) state <= ls_idle;
        default:    state <= ls_idle;
      endcase
    end
  end

  // request latched at the accepting edge
  always_ff @(posedge axis_clk) begin
    if (accept) begin
      r_addr <= wr_req ? s_awaddr : s_araddr;
      r_data <= s_wdata;
      r_strb <= s_wstrb;
    end
  end

  assign s_awready = (state == ls_wr_done) || (state == ls_mb_ack);
  assign s_wready  = s_awready;
  assign s_arready = (state == ls_rd_dec);
  assign s_rvalid  = (state == ls_rd_done);
  // outside the block reads return zero
  assign s_rdata   = (hit_regs || hit_mbox) ? rd_data : '0;

  // block write lands on the ack edge
  assign ls_reg_wr.valid    = (state == ls_mb_ack) || (state == ls_wr_done && hit_regs);
  assign ls_reg_wr.sel_regs = hit_regs;
  assign ls_reg_wr.idx      = r_addr[4:2];
  assign ls_reg_wr.data     = r_data;
  assign ls_reg_wr.strb     = r_strb;
  assign rd_word_sel        = {hit_regs, r_addr[4:2]};

  // ---------------------------------------------------------------------------
  // stream out beats
  // ---------------------------------------------------------------------------
  assign sm_tvalid = (state == ls_wr_sm1) || (state == ls_wr_sm2) ||
                     (state == ls_mb_sm1) || (state == ls_mb_sm2);
  assign hdr_beat  = (state == ls_wr_sm1) || (state == ls_mb_sm1);

  always_comb begin
    sm_beat       = '0;
    sm_beat.tstrb = r_strb;
    sm_beat.tlast = 1'b1;
    sm_beat.tuser = lite_write;
    if (hdr_beat) begin
      sm_beat.tdata.hdr.strb = r_strb;
      sm_beat.tdata.hdr.addr = 28'(r_addr);
    end else begin
      sm_beat.tdata.raw = r_data;
    end
  end

  a_sm_stable : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_beat));

  // the local master keeps a write request up until it is answered
  a_aw_hold : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_awvalid && s_wvalid && !s_awready |=> s_awvalid && s_wvalid && $stable(s_awaddr));

endmodule

//--- verilog/aa_mailbox.sv
// local register block
// interrupt enable and status bits, eight mailbox words,
// read mux and mailbox interrupt
`timescale 1ns/1ps

module aa_mailbox
  import aa_bus_pkg::*, aa_map_pkg::*;
(
  input  logic              axis_clk,
  input  logic              axis_rst_n,
  input  reg_wr_t           ls_reg_wr,
  input  reg_wr_t           rx_reg_wr,
  input  logic [3:0]        rd_word_sel,
  output logic [data_w-1:0] rd_data,
  output logic              mb_irq
);

  // word index bit that picks status, word index starts at address bit 2
  localparam int stat_idx = status_off_bit - 2;

  logic              intr_enable;
  logic              intr_status;
  logic [data_w-1:0] mbox [mbox_words];
  logic              status_clr;
  logic              status_set;

  // byte lane of one mailbox word written by a request
  function automatic logic byte_we(input reg_wr_t wr, input int w, input int b);
    return wr.valid && !wr.sel_regs && (wr.idx == 3'(w)) && wr.strb[b];
  endfunction

  // enable offset write with lane 0 strobed
  function automatic logic enable_we(input reg_wr_t wr);
    return wr.valid && wr.sel_regs && !wr.idx[stat_idx] && wr.strb[0];
  endfunction

  // write-one-to-clear from the local side only
  assign status_clr = ls_reg_wr.valid && ls_reg_wr.sel_regs && ls_reg_wr.idx[stat_idx] &&
                      ls_reg_wr.strb[0] && ls_reg_wr.data[0];
  // any strobed remote mailbox write raises status
  assign status_set = rx_reg_wr.valid && !rx_reg_wr.sel_regs && (|rx_reg_wr.strb);

  // ---------------------------------------------------------------------------
  // control bits
  // ---------------------------------------------------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      intr_enable <= 1'b0;
      intr_status <= 1'b0;
    end else begin
      if (enable_we(ls_reg_wr))      intr_enable <= ls_reg_wr.data[0];
      else if (enable_we(rx_reg_wr)) intr_enable <= rx_reg_wr.data[0];
      // clear wins
      if (status_clr)      intr_status <= 1'b0;
      else if (status_set) intr_status <= 1'b1;
    end
  end

  // mailbox words, per byte, local side first
  always_ff @(posedge axis_clk) begin
    for (int w = 0; w < mbox_words; w++) begin
      for (int b = 0; b < strb_w; b++) begin
        if (byte_we(ls_reg_wr, w, b)) begin
          mbox[w][8*b +: 8] <= ls_reg_wr.data[8*b +: 8];
        end else if (byte_we(rx_reg_wr, w, b)) begin
          mbox[w][8*b +: 8] <= rx_reg_wr.data[8*b +: 8];
        end
      end
    end
  end

  // read mux, bit 3 selects the register page
  assign rd_data = rd_word_sel[3] ?
                   {31'b0, (rd_word_sel[stat_idx] ? intr_status : intr_enable)} :
                   mbox[rd_word_sel[2:0]];

  assign mb_irq = intr_status && intr_enable;

endmodule

//--- verilog/aa_map_pkg.sv
// address map of the local register block
// constants and decode helpers for local and remote addresses
package aa_map_pkg;

  import aa_bus_pkg::*;

  // local slave address, bits 14:12 region and bits 11:8 page
  localparam logic [2:0] blk_base  = 3'b010;
  localparam logic [3:0] regs_page = 4'd1;
  localparam logic [3:0] mbox_page = 4'd0;

  // remote address tags in bits 27:8
  localparam logic [19:0] remote_regs_tag = 20'h00021;
  localparam logic [19:0] remote_mbox_tag = 20'h00020;

  // upper nibble forced onto replayed master writes
  localparam logic [3:0] lm_addr_top = 4'h3;

  // address bit that selects status over enable
  localparam int status_off_bit = 2;
  localparam int mbox_words     = 8;

  function automatic logic ls_hit_regs(input logic [lite_addr_w-1:0] addr);
    return (addr[14:12] == blk_base) && (addr[11:8] == regs_page);
  endfunction

  function automatic logic ls_hit_mbox(input logic [lite_addr_w-1:0] addr);
    return (addr[14:12] == blk_base) && (addr[11:8] == mbox_page);
  endfunction

  function automatic logic rs_hit_regs(input logic [27:0] addr);
    return addr[27:8] == remote_regs_tag;
  endfunction

  function automatic logic rs_hit_mbox(input logic [27:0] addr);
    return addr[27:8] == remote_mbox_tag;
  endfunction

endpackage

//--- verilog/aa_stream_rx.sv
// remote stream receiver
// takes two-beat write cycles, then either writes the local block
// or replays the write on the lite master channel
`timescale 1ns/1ps

module aa_stream_rx
  import aa_bus_pkg::*, aa_map_pkg::*;
(
  input  logic       axis_clk,
  input  logic       axis_rst_n,
  // stream in
  input  logic       ss_tvalid,
  input  axis_beat_t ss_beat,
  output logic       ss_tready,
  // lite master write
  output logic       m_awvalid,
  output logic       m_wvalid,
  output lite_wr_t   m_aw_w,
  input  logic       m_awready,
  input  logic       m_wready,
  // to the lite engine and register block
  output logic       rx_busy,
  output reg_wr_t    rx_reg_wr
);

  typedef enum logic [2:0] {
    rx_idle,
    rx_hdr,
    rx_data,
    rx_reg,
    rx_lm
  } rx_state_e;

  rx_state_e         state;
  stream_hdr_t       r_hdr;
  logic [data_w-1:0] r_data;
  logic              wr_start;
  logic              blk_hit;

  // only write cycles start the receiver
  // other tuser codes stay unaccepted
  assign wr_start = ss_tvalid && (ss_beat.tuser == lite_write);
  assign blk_hit  = rs_hit_regs(r_hdr.addr) || rs_hit_mbox(r_hdr.addr);

  // ---------------------------------------------------------------------------
  // control
  // ---------------------------------------------------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state <= rx_idle;
    end else begin
      case (state)
        rx_idle: if (wr_start) state <= rx_hdr;
        rx_hdr:  if (ss_tvalid) state <= rx_data;
        // route on the latched header once data is in
        rx_data: if (ss_tvalid) state <= blk_hit ? rx_reg : rx_lm;
        rx_reg:  state <= rx_idle;
        rx_lm:   if (m_awready && m_wready) state <= rx_idle;
        default: state <= rx_idle;
      endcase
    end
  end

  // header through the union's header view and data through the raw view
  always_ff @(posedge axis_clk) begin
    if (state == rx_hdr && ss_tvalid) begin
      r_hdr <= ss_beat.tdata.hdr;
    end
    if (state == rx_data && ss_tvalid) begin
      r_data <= ss_beat.tdata.raw;
    end
  end

  assign ss_tready = (state == rx_hdr) || (state == rx_data);
  // also high in the starting idle cycle so the stream side wins a tie
  assign rx_busy   = (state != rx_idle) || wr_start;

  // one-cycle write into the block
  assign rx_reg_wr.valid    = (state == rx_reg);
  assign rx_reg_wr.sel_regs = rs_hit_regs(r_hdr.addr);
  assign rx_reg_wr.idx      = r_hdr.addr[4:2];
  assign rx_reg_wr.data     = r_data;
  assign rx_reg_wr.strb     = r_hdr.strb;

  // aw and w of the master write share one valid
  assign m_awvalid   = (state == rx_lm);
  assign m_wvalid    = m_awvalid;
  assign m_aw_w.addr = {lm_addr_top, r_hdr.addr};
  assign m_aw_w.data = r_data;
  assign m_aw_w.strb = r_hdr.strb;

  // payload must hold until both readies are seen
  a_lm_stable : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    m_awvalid && !(m_awready && m_wready) |=> m_awvalid && $stable(m_aw_w));

  // the peer keeps an offered beat up until it is taken
  a_ss_hold : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    ss_tvalid && !ss_tready |=> ss_tvalid && $stable(ss_beat));

endmodule

//--- vlog.f
verilog/aa_bus_pkg.sv
verilog/aa_map_pkg.sv
verilog/aa_stream_rx.sv
verilog/aa_lite_engine.sv
verilog/aa_mailbox.sv
verilog/aa_bridge_top.sv
verification/aa_clock_gen.sv
verification/aa_bridge_tb.sv
